// File: verilog/sys_arr_pkg.sv
`default_nettype none

package sys_arr_pkg;

    localparam int LANES   = 4;     // adder lanes in one row
    localparam int EXP_W   = 5;
    localparam int FRAC_W  = 10;
    localparam int ALIGN_W = 13;    // hidden bit, fraction, two guard bits

    localparam logic [15:0] FP16_INF = 16'h7C00;    // returned on overflow, sign dropped

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp16_fields_t;

    // one binary16 word, seen as raw bits or as its fields
    typedef union packed {
        logic [15:0]  raw;
        fp16_fields_t f;
    } fp16_t;

    // stage one to stage two
    typedef struct packed {
        logic               sign_shifted;
        logic [ALIGN_W-1:0] frac_shifted;
        logic               sign_unshifted;
        logic [ALIGN_W-1:0] frac_unshifted;
        logic [EXP_W-1:0]   exp_max;
    } align_stage_t;

    // stage two to stage three
    typedef struct packed {
        logic               sign;
        logic [ALIGN_W-1:0] sum;
        logic               carry;
        logic [EXP_W-1:0]   exp_max;
    } sum_stage_t;

    typedef struct packed {
        fp16_t [LANES-1:0] a;
        fp16_t [LANES-1:0] b;
    } operand_vec_t;

    typedef fp16_t [LANES-1:0] result_vec_t;

endpackage

`default_nettype wire

// File: verilog/fp16_align.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_align import sys_arr_pkg::*; (
    input  fp16_t        in_a,
    input  fp16_t        in_b,
    output align_stage_t aligned
);

    logic               a_zero, b_zero;
    logic               a_larger;
    logic [EXP_W-1:0]   exp_diff;
    logic [ALIGN_W-1:0] frac_a, frac_b;

    // zero exponent field means the operand is zero, fraction ignored
    assign a_zero = (in_a.f.exp == '0);
    assign b_zero = (in_b.f.exp == '0);

    assign frac_a = a_zero ? '0 : {1'b1, in_a.f.frac, 2'b00};
    assign frac_b = b_zero ? '0 : {1'b1, in_b.f.frac, 2'b00};

    assign a_larger = (in_a.f.exp >= in_b.f.exp);   // ties keep a unshifted
    assign exp_diff = a_larger ? (in_a.f.exp - in_b.f.exp) : (in_b.f.exp - in_a.f.exp);

    always_comb begin
        if (a_larger) begin
            aligned.sign_unshifted = in_a.f.sign;
            aligned.frac_unshifted = frac_a;
            aligned.sign_shifted   = in_b.f.sign;
            aligned.frac_shifted   = frac_b >> exp_diff;    // bits shifted out are lost
            aligned.exp_max        = in_a.f.exp;
        end else begin
            aligned.sign_unshifted = in_b.f.sign;
            aligned.frac_unshifted = frac_b;
            aligned.sign_shifted   = in_a.f.sign;
            aligned.frac_shifted   = frac_a >> exp_diff;
            aligned.exp_max        = in_b.f.exp;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fp16_sum.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_sum import sys_arr_pkg::*; (
    input  align_stage_t aligned,
    output sum_stage_t   summed
);

    logic [ALIGN_W:0] wide_sum;     // carry in the top bit
    logic             unshifted_larger;

    assign unshifted_larger = (aligned.frac_unshifted >= aligned.frac_shifted);

    always_comb begin
        if (aligned.sign_shifted == aligned.sign_unshifted) begin
            wide_sum    = {1'b0, aligned.frac_unshifted} + {1'b0, aligned.frac_shifted};
            summed.sign = aligned.sign_unshifted;
        end else if (unshifted_larger) begin
            wide_sum    = {1'b0, aligned.frac_unshifted - aligned.frac_shifted};
            summed.sign = aligned.sign_unshifted;
        end else begin
            wide_sum    = {1'b0, aligned.frac_shifted - aligned.frac_unshifted};
            summed.sign = aligned.sign_shifted;
        end
        if (wide_sum == '0) begin
            summed.sign = 1'b0;     // exact cancellation gives +0
        end
        summed.carry   = wide_sum[ALIGN_W];
        summed.sum     = wide_sum[ALIGN_W-1:0];
        summed.exp_max = aligned.exp_max;
    end

endmodule

`default_nettype wire

// File: verilog/fp16_normalize.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_normalize import sys_arr_pkg::*; (
    input  sum_stage_t summed,
    output fp16_t      result,
    output logic       overflow
);

    logic [3:0]              lead_zeros;
    logic [ALIGN_W-1:0]      mant;
    logic signed [EXP_W+1:0] exp_n;     // room for underflow below zero and carry above 31
    logic                    is_zero;

    // count leading zeros, the highest set bit is assigned last
    always_comb begin
        lead_zeros = 4'(ALIGN_W);
        for (int i = 0; i < ALIGN_W; i++) begin
            if (summed.sum[i]) begin
                lead_zeros = 4'(ALIGN_W - 1 - i);
            end
        end
    end

    always_comb begin
        is_zero = 1'b0;
        if (summed.carry) begin
            mant  = {1'b1, summed.sum[ALIGN_W-1:1]};    // one place right
            exp_n = $signed({2'b00, summed.exp_max}) + 7'sd1;
        end else begin
            mant    = summed.sum << lead_zeros;
            exp_n   = $signed({2'b00, summed.exp_max}) - $signed({3'b000, lead_zeros});
            is_zero = (summed.sum == '0);
        end
    end

    always_comb begin
        result.raw = '0;
        overflow   = 1'b0;
        if (is_zero || exp_n < 7'sd1) begin
            result.raw = '0;                // flush to +0
        end else if (exp_n >= 7'sd31) begin
            result.raw = FP16_INF;
            overflow   = 1'b1;
        end else begin
            result.f.sign = summed.sign;
            result.f.exp  = exp_n[EXP_W-1:0];
            result.f.frac = mant[ALIGN_W-2:2];  // guard bits truncated
        end
    end

endmodule

`default_nettype wire

// File: verilog/sysarr_add.sv
`timescale 1ns/1ps
`default_nettype none

module sysarr_add import sys_arr_pkg::*; (
    input  logic  clk,
    input  logic  nRST,
    input  logic  start,
    input  fp16_t add_input1,
    input  fp16_t add_input2,
    output fp16_t add_output,
    output logic  value_ready,
    output logic  overflow
);

    logic         run_latched;
    logic         run;
    logic         start_s2, start_s3;   // start marker riding along with the data
    align_stage_t align_d, align_q;
    sum_stage_t   sum_d, sum_q;

    // held from start until the marker reaches stage three
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            run_latched <= 1'b0;
        end else begin
            run_latched <= (run_latched | start) & ~start_s3;
        end
    end

    assign run         = run_latched | start;   // no lost cycle after start
    assign value_ready = ~run;

    fp16_align align_i (.in_a(add_input1), .in_b(add_input2), .aligned(align_d));

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            align_q  <= '0;
            start_s2 <= 1'b0;
        end else if (run) begin
            align_q  <= align_d;
            start_s2 <= start;
        end
    end

    fp16_sum sum_i (.aligned(align_q), .summed(sum_d));

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            sum_q    <= '0;
            start_s3 <= 1'b0;
        end else if (run) begin
            sum_q    <= sum_d;
            start_s3 <= start_s2;
        end
    end

    // last stage is combinational off the stage-two register
    fp16_normalize norm_i (.summed(sum_q), .result(add_output), .overflow(overflow));

endmodule

`default_nettype wire

// File: verilog/psum_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module psum_feeder import sys_arr_pkg::*; (
    input  logic         clk,
    input  logic         nRST,
    input  logic         load,
    input  operand_vec_t operands,
    input  logic         done,
    output logic         start,
    output operand_vec_t lane_ops,
    output logic         idle
);

    logic accept;

    assign accept = load & idle;    // loads while busy are dropped

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            idle  <= 1'b1;
            start <= 1'b0;
        end else begin
            start <= accept;        // one pulse, the cycle after acceptance
            if (accept) begin
                idle <= 1'b0;
            end else if (done) begin
                idle <= 1'b1;
            end
        end
    end

    // operands are held for the lanes until the next accepted load
    always_ff @(posedge clk) begin
        if (accept) begin
            lane_ops <= operands;
        end
    end

endmodule

`default_nettype wire

// File: verilog/psum_drain.sv
`timescale 1ns/1ps
`default_nettype none

module psum_drain import sys_arr_pkg::*; (
    input  logic             clk,
    input  logic             nRST,
    input  logic             lane_ready,
    input  result_vec_t      lane_results,
    input  logic [LANES-1:0] lane_ovf,
    output logic             done,
    output result_vec_t      results,
    output logic [LANES-1:0] ovf_mask
);

    logic lanes_busy;   // lanes dropped ready since the last capture
    logic capture;

    assign capture = lane_ready & lanes_busy;   // rising edge of readiness

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            lanes_busy <= 1'b0;
            done       <= 1'b0;
            ovf_mask   <= '0;
        end else begin
            done <= capture;
            if (!lane_ready) begin
                lanes_busy <= 1'b1;
            end else if (capture) begin
                lanes_busy <= 1'b0;
                ovf_mask   <= lane_ovf;
            end
        end
    end

    // results stay put until the next capture
    always_ff @(posedge clk) begin
        if (capture) begin
            results <= lane_results;
        end
    end

endmodule

`default_nettype wire

// File: verilog/sysarr_add_row.sv
`timescale 1ns/1ps
`default_nettype none

module sysarr_add_row import sys_arr_pkg::*; (
    input  logic             clk,
    input  logic             nRST,
    input  logic             load,
    input  operand_vec_t     operands,
    output logic             idle,
    output logic             done,
    output result_vec_t      results,
    output logic [LANES-1:0] ovf_mask
);

    logic             start;
    operand_vec_t     lane_ops;
    result_vec_t      lane_out;
    logic [LANES-1:0] lane_ready;
    logic [LANES-1:0] lane_ovf;

    psum_feeder feeder_i (
        .clk(clk), .nRST(nRST), .load(load), .operands(operands), .done(done),
        .start(start), .lane_ops(lane_ops), .idle(idle)
    );

    // identical lanes, all started by the same pulse
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        sysarr_add lane_i (
            .clk(clk), .nRST(nRST), .start(start),
            .add_input1(lane_ops.a[i]), .add_input2(lane_ops.b[i]),
            .add_output(lane_out[i]), .value_ready(lane_ready[i]), .overflow(lane_ovf[i])
        );
    end

    // lanes run in lockstep, so all-ready matches lane 0 ready
    psum_drain drain_i (
        .clk(clk), .nRST(nRST), .lane_ready(&lane_ready), .lane_results(lane_out),
        .lane_ovf(lane_ovf), .done(done), .results(results), .ovf_mask(ovf_mask)
    );

endmodule

`default_nettype wire

// File: test/fp16_ref_model.svh
`ifndef FP16_REF_MODEL_SVH
`define FP16_REF_MODEL_SVH

// builds a binary16 word from its fields
function automatic logic [15:0] fp16_word(input logic sign, input logic [4:0] exp,
                                          input logic [9:0] frac);
    return {sign, exp, frac};
endfunction

// expected sum of two binary16 words, returned as {overflow, result}
function automatic logic [16:0] model_add(input logic [15:0] a, input logic [15:0] b);
    int   exp_a;
    int   exp_b;
    int   exp_r;
    int   mag_a;
    int   mag_b;
    int   total;
    int   mag;
    logic neg;
    exp_a = int'(a[14:10]);
    exp_b = int'(b[14:10]);
    mag_a = (exp_a == 0) ? 0 : (1024 + int'(a[9:0])) * 4;     // hidden bit, two guard bits
    mag_b = (exp_b == 0) ? 0 : (1024 + int'(b[9:0])) * 4;
    if (exp_a >= exp_b) begin
        exp_r = exp_a;
        mag_b = mag_b >> (exp_a - exp_b);
    end else begin
        exp_r = exp_b;
        mag_a = mag_a >> (exp_b - exp_a);
    end
    total = (a[15] ? -mag_a : mag_a) + (b[15] ? -mag_b : mag_b);
    neg   = (total < 0);
    mag   = neg ? -total : total;
    if (mag == 0) begin
        return 17'h0;       // exact cancellation is +0
    end
    if (mag >= 8192) begin
        mag   = mag / 2;    // truncating shift on carry
        exp_r = exp_r + 1;
    end
    while (mag < 4096) begin
        mag   = mag * 2;
        exp_r = exp_r - 1;
    end
    if (exp_r < 1) begin
        return 17'h0;
    end
    if (exp_r >= 31) begin
        return {1'b1, 16'h7C00};   // sign dropped on overflow
    end
    return {1'b0, neg, 5'(exp_r), 10'((mag / 4) % 1024)};
endfunction

`endif

// File: test/tb_sysarr_add_row.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sysarr_add_row import sys_arr_pkg::*; ();

    localparam int NUM_RANDOM  = 40;
    localparam int NUM_VECTORS = NUM_RANDOM + 2;
    localparam int CYCLE_LIMIT = NUM_VECTORS * 50 + 200;

    logic             clk;
    logic             nRST;
    logic             load;
    operand_vec_t     operands;
    logic             idle;
    logic             done;
    result_vec_t      results;
    logic [LANES-1:0] ovf_mask;

    integer seed       = 32'hf8f3_63a6;
    int     cycles     = 0;
    int     done_count = 0;

    `include "fp16_ref_model.svh"

    sysarr_add_row dut_i (
        .clk(clk), .nRST(nRST), .load(load), .operands(operands),
        .idle(idle), .done(done), .results(results), .ovf_mask(ovf_mask)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the row did not finish all vectors within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    // done is sampled mid-cycle away from the edge that changes it
    always @(negedge clk) begin
        if (nRST && done) begin
            done_count++;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;     // inputs change and outputs are read here
    endtask

    function automatic fp16_t random_fp16();
        fp16_t w;
        w.f.sign = 1'($random(seed));
        w.f.exp  = 5'({$random(seed)} % 31);    // 0 to 30
        w.f.frac = 10'($random(seed));
        return w;
    endfunction

    function automatic operand_vec_t random_vec();
        operand_vec_t v;
        for (int i = 0; i < LANES; i++) begin
            v.a[i] = random_fp16();
            v.b[i] = random_fp16();
            if (i % 2 == 1) begin
                v.b[i].f.exp = v.a[i].f.exp;    // equal exponents for deep cancellation
            end
        end
        return v;
    endfunction

    task automatic run_vector(input string name, input operand_vec_t ops);
        logic [16:0]      model;
        result_vec_t      want_res;
        logic [LANES-1:0] want_mask;
        int               edges;
        int               pulses_before;
        for (int i = 0; i < LANES; i++) begin
            model           = model_add(ops.a[i].raw, ops.b[i].raw);
            want_res[i].raw = model[15:0];
            want_mask[i]    = model[16];
        end
        while (!idle) begin
            next_cycle();
        end
        pulses_before = done_count;
        load          = 1'b1;
        operands      = ops;
        next_cycle();                   // acceptance edge
        load  = 1'b0;
        edges = 0;
        check({name, " idle after load"}, 0, idle);
        while (!done) begin
            next_cycle();
            edges++;
            load     = (edges == 1);    // stray load while busy
            operands = random_vec();
            check({name, " idle while busy"}, 0, idle);
        end
        check({name, " edges to done"}, 4, edges);
        for (int i = 0; i < LANES; i++) begin
            check($sformatf("%s lane %0d", name, i), want_res[i], results[i]);
        end
        check({name, " overflow mask"}, want_mask, ovf_mask);
        next_cycle();
        check({name, " done pulse width"}, 0, done);
        check({name, " done pulse count"}, pulses_before + 1, done_count);
        check({name, " idle after done"}, 1, idle);
        for (int i = 0; i < LANES; i++) begin
            check($sformatf("%s lane %0d held", name, i), want_res[i], results[i]);
        end
    endtask

    initial begin
        operand_vec_t vec;
        result_vec_t  expect_res;
        fp16_t        x;
        nRST     = 1'b0;
        load     = 1'b0;
        operands = '0;
        repeat (8) @(posedge clk);
        #2;
        nRST = 1'b1;
        next_cycle();
        check("reset idle", 1, idle);
        check("reset done", 0, done);
        check("reset overflow mask", 0, ovf_mask);

        // large operands near the top exponent with alternating signs
        for (int i = 0; i < LANES; i++) begin
            vec.a[i].raw = fp16_word(i[0], 5'd30, 10'h3ff);
            vec.b[i].raw = fp16_word(i[0], 5'(30 - i % 4), 10'h3ff);
        end
        run_vector("overflow", vec);
        for (int i = 0; i < LANES; i++) begin
            check($sformatf("overflow lane %0d infinity", i), 16'h7C00, results[i]);
        end
        check("overflow mask all set", {LANES{1'b1}}, ovf_mask);

        // cancellation and zero-exponent operands
        for (int i = 0; i < LANES; i++) begin
            x = random_fp16();
            if (x.f.exp == 5'd0) begin
                x.f.exp = 5'd15;
            end
            case (i % 4)
                0: begin
                    vec.a[i] = x;
                    vec.b[i].raw = {~x.f.sign, x.raw[14:0]};
                    expect_res[i].raw = 16'h0000;
                end
                1: begin
                    vec.a[i].raw = fp16_word(1'b0, 5'd0, 10'h2a5);
                    vec.b[i] = x;
                    expect_res[i] = x;
                end
                2: begin
                    vec.a[i] = x;
                    vec.b[i].raw = fp16_word(1'b1, 5'd0, 10'h3ff);
                    expect_res[i] = x;
                end
                default: begin
                    vec.a[i].raw = fp16_word(1'b1, 5'd0, 10'h155);
                    vec.b[i].raw = fp16_word(1'b0, 5'd0, 10'h0aa);
                    expect_res[i].raw = 16'h0000;
                end
            endcase
        end
        run_vector("zero", vec);
        for (int i = 0; i < LANES; i++) begin
            check($sformatf("zero lane %0d direct", i), expect_res[i], results[i]);
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            run_vector($sformatf("random %0d", n), random_vec());
        end
        check("total done pulses", NUM_VECTORS, done_count);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+test
verilog/sys_arr_pkg.sv
verilog/fp16_align.sv
verilog/fp16_sum.sv
verilog/fp16_normalize.sv
verilog/sysarr_add.sv
verilog/psum_feeder.sv
verilog/psum_drain.sv
verilog/sysarr_add_row.sv
test/tb_sysarr_add_row.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_sysarr_add_row
RTL_TOP    = sysarr_add_row
FILELIST   = build.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
